// File: vp8_coef_pkg.sv
/*
 * VP8 coefficient definitions
 * Coefficient and quantizer widths, inverse DCT multipliers
 * and the zigzag to raster mapping
 */
`default_nettype none

package vp8_coef_pkg;

    // --------------------
    // Widths
    // Quantized residual, signed
    localparam int COEF_W = 12;
    // Dequantized residual, signed and saturated
    localparam int DQ_W   = 16;
    // Quantizer factor, unsigned
    localparam int Q_W    = 9;

    // --------------------
    // Inverse DCT multipliers in Q16
    // sqrt(2) * sin(pi/8)
    localparam int K_SIN = 35468;
    // sqrt(2) * cos(pi/8), kept as 20091 + 65536
    localparam int K_COS = 85627;

    // --------------------
    // Zigzag index feeding each raster position
    localparam int ZIGZAG [16] = '{
        0,  1,  5,  6,
        2,  4,  7,  12,
        3,  8,  11, 13,
        9,  10, 14, 15
    };

endpackage

`default_nettype wire

// File: vp8_pix_pkg.sv
/*
 * VP8 pixel definitions
 * Pixel width, 4x4 block size and the clamp limit
 */
`default_nettype none

package vp8_pix_pkg;

    // --------------------
    // Pixel format
    localparam int PIX_W   = 8;
    localparam int PIX_MAX = 255;

    // --------------------
    // Block geometry
    // 4x4 pixels per block
    localparam int BLK_N = 16;

endpackage

`default_nettype wire

// File: coeff_dequant.sv
/*
 * Coefficient decode stage
 * Dequantizes one block of zigzag-ordered coefficients with saturation
 * and writes them out in raster order, one cycle after the input
 */
`timescale 1ns/1ps
`default_nettype none

module coeff_dequant (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                blk_valid_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_coef_pkg::COEF_W-1:0] coef_i,
    input  wire  [vp8_coef_pkg::Q_W-1:0]                       dc_q_i,
    input  wire  [vp8_coef_pkg::Q_W-1:0]                       ac_q_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]   pred_i,
    output logic                                               dq_valid_o,
    output logic [vp8_pix_pkg::BLK_N*vp8_coef_pkg::DQ_W-1:0]   dq_coef_o,
    output logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]   dq_pred_o
);

    localparam int N      = vp8_pix_pkg::BLK_N;
    localparam int COEF_W = vp8_coef_pkg::COEF_W;
    localparam int DQ_W   = vp8_coef_pkg::DQ_W;
    localparam int Q_W    = vp8_coef_pkg::Q_W;
    // Signed coefficient times zero-extended factor
    localparam int PROD_W = COEF_W + Q_W + 1;

    logic [N*DQ_W-1:0] dq_next;

    // Clip a product into the signed DQ_W range
    function automatic logic [DQ_W-1:0] sat_dq(input logic signed [PROD_W-1:0] p);
        logic [PROD_W-DQ_W:0] top;
        top = p[PROD_W-1:DQ_W-1];
        // All upper bits equal to the sign means it fits
        if (&top || !(|top)) begin
            return p[DQ_W-1:0];
        end
        return p[PROD_W-1] ? {1'b1, {(DQ_W-1){1'b0}}} : {1'b0, {(DQ_W-1){1'b1}}};
    endfunction

    // --------------------
    // Dequantize and reorder
    for (genvar r = 0; r < N; r++) begin : g_pos
        localparam int Z = vp8_coef_pkg::ZIGZAG[r];

        logic signed [COEF_W-1:0] coef_z;
        logic signed [Q_W:0]      q_s;
        logic signed [PROD_W-1:0] prod;

        assign coef_z = coef_i[Z*COEF_W +: COEF_W];
        // Only zigzag index 0 is the DC term
        assign q_s    = (Z == 0) ? {1'b0, dc_q_i} : {1'b0, ac_q_i};
        assign prod   = PROD_W'(coef_z) * PROD_W'(q_s);

        assign dq_next[r*DQ_W +: DQ_W] = sat_dq(prod);
    end

    // --------------------
    // Output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dq_valid_o <= 1'b0;
        end else begin
            dq_valid_o <= blk_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            dq_coef_o <= dq_next;
            dq_pred_o <= pred_i;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(blk_valid_i));

endmodule

`default_nettype wire

// File: idct4x4_recon.sv
/*
 * Block execute stage
 * Two-pass VP8 4x4 inverse DCT, prediction add and clamp to 0..255
 * Column pass in the first register, clamped pixels in the second
 */
`timescale 1ns/1ps
`default_nettype none

module idct4x4_recon (
    input  wire                                               clk,
    input  wire                                               rst_n,
    input  wire                                               dq_valid_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_coef_pkg::DQ_W-1:0]  dq_coef_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]  dq_pred_i,
    output logic                                              rec_valid_o,
    output logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]  rec_pix_o
);

    localparam int N     = vp8_pix_pkg::BLK_N;
    localparam int DQ_W  = vp8_coef_pkg::DQ_W;
    localparam int PIX_W = vp8_pix_pkg::PIX_W;
    // Headroom for both passes, the rounding offset and the prediction add
    localparam int ACC_W = 24;
    localparam int MUL_W = 48;

    logic signed [ACC_W-1:0] coef  [N];
    logic signed [ACC_W-1:0] col_d [N];
    logic signed [ACC_W-1:0] col_q [N];
    logic signed [ACC_W-1:0] row_d [N];
    logic [N*PIX_W-1:0]      pred_q;
    logic [N*PIX_W-1:0]      pix_d;
    logic                    valid_q;

    // Q16 multiply, arithmetic shift right by 16
    function automatic logic signed [ACC_W-1:0] mul_q16(
        input logic signed [ACC_W-1:0] x,
        input int                      k
    );
        logic signed [MUL_W-1:0] p;
        p = MUL_W'(x) * MUL_W'(k);
        return p[ACC_W+15:16];
    endfunction

    // Each pixel clamps on its own value
    function automatic logic [PIX_W-1:0] clamp_pix(input logic signed [ACC_W-1:0] v);
        if (v[ACC_W-1]) begin
            return '0;
        end
        if (v > ACC_W'(vp8_pix_pkg::PIX_MAX)) begin
            return PIX_W'(vp8_pix_pkg::PIX_MAX);
        end
        return v[PIX_W-1:0];
    endfunction

    for (genvar k = 0; k < N; k++) begin : g_unpack
        assign coef[k] = ACC_W'(signed'(dq_coef_i[k*DQ_W +: DQ_W]));
    end

    // --------------------
    // Column pass, vertical butterfly
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [ACC_W-1:0] a0;
        logic signed [ACC_W-1:0] a1;
        logic signed [ACC_W-1:0] a2;
        logic signed [ACC_W-1:0] a3;

        assign a0 = coef[c] + coef[c+8];
        assign a1 = coef[c] - coef[c+8];
        assign a2 = mul_q16(coef[c+4], vp8_coef_pkg::K_SIN)
                  - mul_q16(coef[c+12], vp8_coef_pkg::K_COS);
        assign a3 = mul_q16(coef[c+4], vp8_coef_pkg::K_COS)
                  + mul_q16(coef[c+12], vp8_coef_pkg::K_SIN);

        // Results stay in raster order
        assign col_d[c]    = a0 + a3;
        assign col_d[c+4]  = a1 + a2;
        assign col_d[c+8]  = a1 - a2;
        assign col_d[c+12] = a0 - a3;
    end

    // --------------------
    // Row pass, horizontal butterfly with rounding
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [ACC_W-1:0] b0;
        logic signed [ACC_W-1:0] b1;
        logic signed [ACC_W-1:0] b2;
        logic signed [ACC_W-1:0] b3;

        assign b0 = col_q[4*r] + col_q[4*r+2] + ACC_W'(4);
        assign b1 = col_q[4*r] - col_q[4*r+2] + ACC_W'(4);
        assign b2 = mul_q16(col_q[4*r+1], vp8_coef_pkg::K_SIN)
                  - mul_q16(col_q[4*r+3], vp8_coef_pkg::K_COS);
        assign b3 = mul_q16(col_q[4*r+1], vp8_coef_pkg::K_COS)
                  + mul_q16(col_q[4*r+3], vp8_coef_pkg::K_SIN);

        assign row_d[4*r]   = (b0 + b3) >>> 3;
        assign row_d[4*r+1] = (b1 + b2) >>> 3;
        assign row_d[4*r+2] = (b1 - b2) >>> 3;
        assign row_d[4*r+3] = (b0 - b3) >>> 3;
    end

    // Prediction add and clamp
    for (genvar k = 0; k < N; k++) begin : g_pix
        logic signed [ACC_W-1:0] sum;

        assign sum = row_d[k] + signed'(ACC_W'(pred_q[k*PIX_W +: PIX_W]));
        assign pix_d[k*PIX_W +: PIX_W] = clamp_pix(sum);
    end

    // --------------------
    // Pipeline registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            rec_valid_o <= 1'b0;
        end else begin
            valid_q     <= dq_valid_i;
            rec_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (dq_valid_i) begin
            col_q  <= col_d;
            pred_q <= dq_pred_i;
        end
        if (valid_q) begin
            rec_pix_o <= pix_d;
        end
    end

    a_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        dq_valid_i |-> ##2 rec_valid_o);

    a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid_o |-> $past(dq_valid_i, 2));

endmodule

`default_nettype wire

// File: recon_block_fifo.sv
/*
 * Block result stage
 * Circular buffer of reconstructed blocks released against downstream
 * credits, with one upstream credit returned per block that leaves
 */
`timescale 1ns/1ps
`default_nettype none

module recon_block_fifo #(
    parameter int FIFO_DEPTH       = 4,
    parameter int DOWN_CREDITS_MAX = 4
) (
    input  wire                                               clk,
    input  wire                                               rst_n,
    input  wire                                               rec_valid_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]  rec_pix_i,
    input  wire                                               down_credit_i,
    output logic                                              out_valid_o,
    output logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]  out_pix_o,
    output logic                                              up_credit_o
);

    localparam int BLK_W = vp8_pix_pkg::BLK_N * vp8_pix_pkg::PIX_W;
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(DOWN_CREDITS_MAX + 1);

    logic [BLK_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic             empty;
    logic             full;
    logic             pop;
    logic [BLK_W-1:0] head;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    // --------------------
    // Pop decision
    assign empty = (fill == '0);
    assign full  = (fill == CNT_W'(FIFO_DEPTH));
    // Empty buffer passes the incoming block straight through
    assign pop   = (credits != '0) && (!empty || rec_valid_i);
    assign head  = empty ? rec_pix_i : mem[rd_ptr];

    // A slot goes back upstream as its block leaves
    assign up_credit_o = out_valid_o;

    always_ff @(posedge clk) begin
        if (rec_valid_i) begin
            mem[wr_ptr] <= rec_pix_i;
        end
        if (pop) begin
            out_pix_o <= head;
        end
    end

    // --------------------
    // Pointers, fill and credits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            credits     <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= pop;
            if (rec_valid_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({rec_valid_i, pop})
                2'b10:   fill <= fill + CNT_W'(1);
                2'b01:   fill <= fill - CNT_W'(1);
                default: fill <= fill;
            endcase
            case ({down_credit_i, pop})
                2'b10: begin
                    // Saturate at the limit
                    if (credits != CRD_W'(DOWN_CREDITS_MAX)) begin
                        credits <= credits + CRD_W'(1);
                    end
                end
                2'b01:   credits <= credits - CRD_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid_i |-> !full);

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        (down_credit_i && !pop) |-> (credits != CRD_W'(DOWN_CREDITS_MAX)));

endmodule

`default_nettype wire

// File: vp8_recon_top.sv
/*
 * VP8 block reconstruction
 * Dequantize, inverse transform with prediction add, and a credit
 * controlled block buffer towards the consumer
 */
`timescale 1ns/1ps
`default_nettype none

module vp8_recon_top #(
    parameter int FIFO_DEPTH       = 4,
    parameter int DOWN_CREDITS_MAX = 4
) (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                blk_valid_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_coef_pkg::COEF_W-1:0] coef_i,
    input  wire  [vp8_coef_pkg::Q_W-1:0]                       dc_q_i,
    input  wire  [vp8_coef_pkg::Q_W-1:0]                       ac_q_i,
    input  wire  [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]   pred_i,
    output logic                                               up_credit_o,
    output logic                                               out_valid_o,
    output logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0]   out_pix_o,
    input  wire                                                down_credit_i
);

    // --------------------
    // Stage links
    logic                                             dq_valid;
    logic [vp8_pix_pkg::BLK_N*vp8_coef_pkg::DQ_W-1:0] dq_coef;
    logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0] dq_pred;
    logic                                             rec_valid;
    logic [vp8_pix_pkg::BLK_N*vp8_pix_pkg::PIX_W-1:0] rec_pix;

    // Decode
    coeff_dequant i_dequant (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_valid_i (blk_valid_i),
        .coef_i      (coef_i),
        .dc_q_i      (dc_q_i),
        .ac_q_i      (ac_q_i),
        .pred_i      (pred_i),
        .dq_valid_o  (dq_valid),
        .dq_coef_o   (dq_coef),
        .dq_pred_o   (dq_pred)
    );

    // Execute
    idct4x4_recon i_idct (
        .clk         (clk),
        .rst_n       (rst_n),
        .dq_valid_i  (dq_valid),
        .dq_coef_i   (dq_coef),
        .dq_pred_i   (dq_pred),
        .rec_valid_o (rec_valid),
        .rec_pix_o   (rec_pix)
    );

    // Result buffer
    recon_block_fifo #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .DOWN_CREDITS_MAX (DOWN_CREDITS_MAX)
    ) i_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .rec_valid_i   (rec_valid),
        .rec_pix_i     (rec_pix),
        .down_credit_i (down_credit_i),
        .out_valid_o   (out_valid_o),
        .out_pix_o     (out_pix_o),
        .up_credit_o   (up_credit_o)
    );

endmodule

`default_nettype wire

// File: tb_vp8_model.svh
/*
 * Testbench reference model
 * Dequantization, zigzag reorder, VP8 inverse DCT, prediction add and
 * clamp, plus the 32-bit xorshift generator for random stimulus
 */
`ifndef TB_VP8_MODEL_SVH
`define TB_VP8_MODEL_SVH
`default_nettype none

// Raster position of each zigzag index, as in the VP8 scan order
localparam int RASTER_OF [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Odd-term multipliers in the reference decoder's form
function automatic longint mul_sin(input longint x);
    return (x * 35468) >>> 16;
endfunction

function automatic longint mul_cos(input longint x);
    return x + ((x * 20091) >>> 16);
endfunction

function automatic logic [BLK_W-1:0] model_block(
    input logic [COEF_BUS_W-1:0] coef,
    input logic [Q_W-1:0]        dc_q,
    input logic [Q_W-1:0]        ac_q,
    input logic [BLK_W-1:0]      pred
);
    longint           res [16];
    longint           tmp [16];
    longint           v;
    longint           a1;
    longint           b1;
    longint           c1;
    longint           d1;
    logic [BLK_W-1:0] pix;
    // Dequantize with 16-bit saturation, then undo the zigzag scan
    for (int z = 0; z < 16; z++) begin
        v = longint'($signed(coef[z*COEF_W +: COEF_W])) * longint'((z == 0) ? dc_q : ac_q);
        if (v > 32767)
            v = 32767;
        if (v < -32768)
            v = -32768;
        res[RASTER_OF[z]] = v;
    end
    // Vertical pass
    for (int c = 0; c < 4; c++) begin
        a1 = res[c] + res[c+8];
        b1 = res[c] - res[c+8];
        c1 = mul_sin(res[c+4]) - mul_cos(res[c+12]);
        d1 = mul_cos(res[c+4]) + mul_sin(res[c+12]);
        tmp[c]    = a1 + d1;
        tmp[c+4]  = b1 + c1;
        tmp[c+8]  = b1 - c1;
        tmp[c+12] = a1 - d1;
    end
    // Horizontal pass with rounding
    for (int r = 0; r < 4; r++) begin
        a1 = tmp[4*r] + tmp[4*r+2];
        b1 = tmp[4*r] - tmp[4*r+2];
        c1 = mul_sin(tmp[4*r+1]) - mul_cos(tmp[4*r+3]);
        d1 = mul_cos(tmp[4*r+1]) + mul_sin(tmp[4*r+3]);
        res[4*r]   = (a1 + d1 + 4) >>> 3;
        res[4*r+1] = (b1 + c1 + 4) >>> 3;
        res[4*r+2] = (b1 - c1 + 4) >>> 3;
        res[4*r+3] = (a1 - d1 + 4) >>> 3;
    end
    // Prediction add, each pixel clamped on its own
    for (int k = 0; k < 16; k++) begin
        v = res[k] + longint'(pred[k*8 +: 8]);
        if (v < 0)
            v = 0;
        if (v > 255)
            v = 255;
        pix[k*8 +: 8] = 8'(v);
    end
    return pix;
endfunction

`default_nettype wire
`endif

// File: tb_vp8_recon.sv
/*
 * Testbench for the VP8 block reconstruction top level
 * Acts as the credit-holding source and the consumer, and checks each
 * reconstructed block against the reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vp8_recon;

    localparam int COEF_W     = vp8_coef_pkg::COEF_W;
    localparam int Q_W        = vp8_coef_pkg::Q_W;
    localparam int COEF_BUS_W = vp8_pix_pkg::BLK_N * COEF_W;
    localparam int BLK_W      = vp8_pix_pkg::BLK_N * vp8_pix_pkg::PIX_W;
    localparam int DEPTH      = 4;
    localparam int CRD_MAX    = 4;
    localparam int TIMEOUT    = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  blk_valid_i;
    logic [COEF_BUS_W-1:0] coef_i;
    logic [Q_W-1:0]        dc_q_i;
    logic [Q_W-1:0]        ac_q_i;
    logic [BLK_W-1:0]      pred_i;
    logic                  up_credit_o;
    logic                  out_valid_o;
    logic [BLK_W-1:0]      out_pix_o;
    logic                  down_credit_i;

    // Credit and block bookkeeping, each counter has a single writer
    int                    up_sent     = 0;
    int                    up_returned = 0;
    int                    down_given  = 0;
    int                    blocks_seen = 0;
    logic [31:0]           rng         = 32'hd5f9;
    logic [BLK_W-1:0]      exp_mem [32];
    logic [BLK_W-1:0]      got_mem [32];
    // Staged stimulus of the running test
    logic [COEF_BUS_W-1:0] st_coef [32];
    logic [Q_W-1:0]        st_dc   [32];
    logic [Q_W-1:0]        st_ac   [32];
    logic [BLK_W-1:0]      st_pred [32];

    vp8_recon_top #(
        .FIFO_DEPTH       (DEPTH),
        .DOWN_CREDITS_MAX (CRD_MAX)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .blk_valid_i   (blk_valid_i),
        .coef_i        (coef_i),
        .dc_q_i        (dc_q_i),
        .ac_q_i        (ac_q_i),
        .pred_i        (pred_i),
        .up_credit_o   (up_credit_o),
        .out_valid_o   (out_valid_o),
        .out_pix_o     (out_pix_o),
        .down_credit_i (down_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Output monitor on the registered DUT outputs
    always @(posedge clk) begin
        if (rst_n) begin
            check(BLK_W'(up_credit_o), BLK_W'(out_valid_o), "up_credit_o with out_valid_o");
            if (out_valid_o) begin
                got_mem[blocks_seen] <= out_pix_o;
                blocks_seen <= blocks_seen + 1;
            end
            if (up_credit_o)
                up_returned <= up_returned + 1;
        end
    end

    // --------------------
    // Helpers
    task automatic fail_stop();
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input logic [BLK_W-1:0] got, input logic [BLK_W-1:0] exp,
                         input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic timeout_stop(input string what);
        $display("Timed out while waiting for %s", what);
        fail_stop();
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] draw();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic stage_random(input int i);
        logic [31:0] r;
        for (int k = 0; k < 16; k++) begin
            r = draw();
            st_coef[i][k*COEF_W +: COEF_W] = COEF_W'($signed(r[5:0]));
            st_pred[i][k*8 +: 8] = r[15:8];
        end
        r = draw();
        st_dc[i] = Q_W'(r[6:0]) + Q_W'(1);
        st_ac[i] = Q_W'(r[14:8]) + Q_W'(1);
    endtask

    // Present one staged block once the source holds a credit
    task automatic send_block(input int i);
        int waited;
        waited = 0;
        while (DEPTH - up_sent + up_returned <= 0) begin
            step();
            waited++;
            if (waited > TIMEOUT)
                timeout_stop("an upstream credit");
        end
        exp_mem[up_sent] = model_block(st_coef[i], st_dc[i], st_ac[i], st_pred[i]);
        up_sent++;
        blk_valid_i = 1'b1;
        coef_i      = st_coef[i];
        dc_q_i      = st_dc[i];
        ac_q_i      = st_ac[i];
        pred_i      = st_pred[i];
        step();
        blk_valid_i = 1'b0;
    endtask

    task automatic give_credit();
        down_credit_i = 1'b1;
        down_given++;
        step();
        down_credit_i = 1'b0;
    endtask

    task automatic wait_blocks(input int count);
        int waited;
        waited = 0;
        while (blocks_seen < count) begin
            step();
            waited++;
            if (waited > TIMEOUT)
                timeout_stop("reconstructed blocks");
        end
    endtask

    task automatic check_blocks(input int first, input int last);
        for (int b = first; b < last; b++)
            check(got_mem[b], exp_mem[b], $sformatf("block %0d", b));
    endtask

    // Send n staged blocks while the consumer keeps credits topped up
    task automatic stream_blocks(input int n);
        int base;
        base = up_sent;
        fork
            begin
                for (int i = 0; i < n; i++)
                    send_block(i);
            end
            begin : credit_feed
                int waited;
                waited = 0;
                while (down_given < base + n) begin
                    if (down_given - blocks_seen < CRD_MAX)
                        give_credit();
                    else
                        step();
                    waited++;
                    if (waited > TIMEOUT)
                        timeout_stop("room for a downstream credit");
                end
            end
        join
        wait_blocks(base + n);
        check_blocks(base, base + n);
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset_state();
        give_credit();
        for (int c = 0; c < 10; c++) begin
            check(BLK_W'(out_valid_o), '0, "out_valid_o idle after reset");
            check(BLK_W'(up_credit_o), '0, "up_credit_o idle after reset");
            step();
        end
    endtask

    task automatic test_dc_only();
        int base;
        int dc;
        int pix;
        base = up_sent;
        stage_random(0);
        st_coef[0] = '0;
        st_coef[0][0 +: COEF_W] = COEF_W'(-37);
        st_dc[0] = Q_W'(23);
        stream_blocks(1);
        // Flat residual over the whole block
        dc = (-37 * 23 + 4) >>> 3;
        for (int k = 0; k < 16; k++) begin
            pix = int'(st_pred[0][k*8 +: 8]) + dc;
            pix = (pix < 0) ? 0 : ((pix > 255) ? 255 : pix);
            check(BLK_W'(got_mem[base][k*8 +: 8]), BLK_W'(pix), $sformatf("DC pixel %0d", k));
        end
    endtask

    task automatic test_random_blocks();
        for (int i = 0; i < 20; i++)
            stage_random(i);
        stream_blocks(20);
    endtask

    task automatic test_saturation();
        int base;
        base = up_sent;
        for (int i = 0; i < 3; i++) begin
            st_coef[i] = '0;
            st_dc[i]   = Q_W'(511);
            st_ac[i]   = Q_W'(511);
            st_pred[i] = {16{8'd250}};
        end
        st_coef[0][0 +: COEF_W] = COEF_W'(2047);
        st_coef[1][0 +: COEF_W] = COEF_W'(-2048);
        st_pred[1] = {16{8'd5}};
        // First horizontal AC term, left half high and right half low
        st_coef[2][COEF_W +: COEF_W] = COEF_W'(2047);
        stream_blocks(3);
        check(got_mem[base], {16{8'hff}}, "high saturation");
        check(got_mem[base + 1], '0, "low saturation");
        check(got_mem[base + 2], {4{32'h0000_ffff}}, "clamp per pixel");
    endtask

    task automatic test_credit_flow();
        int base;
        base = blocks_seen;
        check(BLK_W'(down_given - blocks_seen), '0, "no downstream credits left");
        for (int i = 0; i < 4; i++)
            stage_random(i);
        for (int i = 0; i < 4; i++)
            send_block(i);
        check(BLK_W'(DEPTH - up_sent + up_returned), '0, "source credits spent");
        // Blocks park in the buffer
        for (int c = 0; c < 20; c++) begin
            check(BLK_W'(out_valid_o), '0, "out_valid_o without credit");
            check(BLK_W'(up_credit_o), '0, "up_credit_o without credit");
            step();
        end
        give_credit();
        wait_blocks(base + 1);
        repeat (10) step();
        check(BLK_W'(blocks_seen - base), BLK_W'(1), "one block per credit");
        check(BLK_W'(DEPTH - up_sent + up_returned), BLK_W'(1), "one upstream credit back");
        for (int i = 0; i < 3; i++)
            give_credit();
        wait_blocks(base + 4);
        check_blocks(base, base + 4);
        check(BLK_W'(DEPTH - up_sent + up_returned), BLK_W'(DEPTH), "all source credits back");
    endtask

    // --------------------
    // Main sequence
    initial begin
        rst_n         = 1'b0;
        blk_valid_i   = 1'b0;
        coef_i        = '0;
        dc_q_i        = '0;
        ac_q_i        = '0;
        pred_i        = '0;
        down_credit_i = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        test_reset_state();
        test_dc_only();
        test_random_blocks();
        test_saturation();
        test_credit_flow();
        $display("All tests passed!");
        $finish;
    end

    `include "tb_vp8_model.svh"

endmodule

`default_nettype wire

// File: all.f
+incdir+.
vp8_coef_pkg.sv
vp8_pix_pkg.sv
coeff_dequant.sv
idct4x4_recon.sv
recon_block_fifo.sv
vp8_recon_top.sv
tb_vp8_recon.sv

// File: run.sh
#!/bin/sh
# Build and run the VP8 reconstruction testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vp8_recon -f all.f -Mdir obj_dir

output=$(./obj_dir/Vtb_vp8_recon 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1
